//--- common/mipsPkg.sv
package mipsPkg;

    // primary opcodes.
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opAddi    = 6'h08;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opSlti    = 6'h0a;
    localparam logic [5:0] opSltiu   = 6'h0b;
    localparam logic [5:0] opAndi    = 6'h0c;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opXori    = 6'h0e;
    localparam logic [5:0] opLui     = 6'h0f;

    // funct codes under SPECIAL.
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSra  = 6'h03;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnSrav = 6'h07;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;
    localparam logic [5:0] fnSlt  = 6'h2a;
    localparam logic [5:0] fnSltu = 6'h2b;

    // APB register map, register n sits at addrGprBase + 4n.
    localparam logic [11:0] addrInstr   = 12'h000;
    localparam logic [11:0] addrStatus  = 12'h004;
    localparam logic [11:0] addrGprBase = 12'h080;

    // one instruction word, seen as R-type or I-type.
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iType;
    } instrWordT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
        aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
    } aluOpT;

    typedef struct packed {
        aluOpT       aluOp;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] immValue;
        logic        useImm;
        logic [4:0]  shamt;
        logic        shiftByReg;
        logic        regWrite;
        logic [4:0]  writeReg;
        logic        illegal;
    } decodedT;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRspT;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        logic [4:0]  writeReg;
        logic [31:0] data;
        logic        illegal;
    } wbT;

endpackage

//--- decode/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
    input  mipsPkg::instrWordT instrWord,
    output logic [4:0]         rsId,
    output logic [4:0]         rtId,
    output mipsPkg::decodedT   decoded
);

    logic [5:0]  op;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic [31:0] signExt;
    logic [31:0] zeroExt;
    logic        illegal;

    assign op      = instrWord.rType.op;
    assign funct   = instrWord.rType.funct;
    assign imm16   = instrWord.iType.imm16;
    assign signExt = {{16{imm16[15]}}, imm16};
    assign zeroExt = {16'h0000, imm16};

    assign rsId = instrWord.rType.rs;
    assign rtId = instrWord.rType.rt;

    always_comb begin
        illegal             = 1'b0;
        decoded             = '0;
        decoded.aluOp       = mipsPkg::aluAdd;
        decoded.rs          = instrWord.rType.rs;
        decoded.rt          = instrWord.rType.rt;
        decoded.shamt       = instrWord.rType.shamt;
        decoded.immValue    = signExt;
        // I-type writes rt, R-type overrides below.
        decoded.writeReg    = instrWord.iType.rt;
        case (op)
            mipsPkg::opSpecial: begin
                decoded.writeReg = instrWord.rType.rd;
                case (funct)
                    mipsPkg::fnAdd, mipsPkg::fnAddu: decoded.aluOp = mipsPkg::aluAdd;
                    mipsPkg::fnSub, mipsPkg::fnSubu: decoded.aluOp = mipsPkg::aluSub;
                    mipsPkg::fnAnd:  decoded.aluOp = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   decoded.aluOp = mipsPkg::aluOr;
                    mipsPkg::fnXor:  decoded.aluOp = mipsPkg::aluXor;
                    mipsPkg::fnNor:  decoded.aluOp = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  decoded.aluOp = mipsPkg::aluSlt;
                    mipsPkg::fnSltu: decoded.aluOp = mipsPkg::aluSltu;
                    mipsPkg::fnSll:  decoded.aluOp = mipsPkg::aluSll;
                    mipsPkg::fnSrl:  decoded.aluOp = mipsPkg::aluSrl;
                    mipsPkg::fnSra:  decoded.aluOp = mipsPkg::aluSra;
                    mipsPkg::fnSllv: begin
                        decoded.aluOp      = mipsPkg::aluSll;
                        decoded.shiftByReg = 1'b1;
                    end
                    mipsPkg::fnSrlv: begin
                        decoded.aluOp      = mipsPkg::aluSrl;
                        decoded.shiftByReg = 1'b1;
                    end
                    mipsPkg::fnSrav: begin
                        decoded.aluOp      = mipsPkg::aluSra;
                        decoded.shiftByReg = 1'b1;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            // no overflow traps, so addi is addiu.
            mipsPkg::opAddi, mipsPkg::opAddiu: decoded.aluOp = mipsPkg::aluAdd;
            mipsPkg::opSlti:  decoded.aluOp = mipsPkg::aluSlt;
            mipsPkg::opSltiu: decoded.aluOp = mipsPkg::aluSltu;
            mipsPkg::opAndi: begin
                decoded.aluOp    = mipsPkg::aluAnd;
                decoded.immValue = zeroExt;
            end
            mipsPkg::opOri: begin
                decoded.aluOp    = mipsPkg::aluOr;
                decoded.immValue = zeroExt;
            end
            mipsPkg::opXori: begin
                decoded.aluOp    = mipsPkg::aluXor;
                decoded.immValue = zeroExt;
            end
            mipsPkg::opLui: begin
                decoded.aluOp    = mipsPkg::aluLui;
                decoded.immValue = {imm16, 16'h0000};
            end
            default: illegal = 1'b1;
        endcase
        decoded.useImm   = (op != mipsPkg::opSpecial);
        decoded.illegal  = illegal;
        decoded.regWrite = !illegal;
    end

endmodule

//--- execute/aluExecute.sv
`timescale 1ns/10ps

module aluExecute (
    input  logic             clk,
    input  logic             rstN,
    input  logic             issueValid,
    input  mipsPkg::decodedT decoded,
    input  logic [31:0]      rsData,
    input  logic [31:0]      rtData,
    output mipsPkg::wbT      wb
);

    logic [31:0] opB;
    logic [4:0]  shiftAmt;
    logic [31:0] result;

    assign opB      = decoded.useImm ? decoded.immValue : rtData;
    // variable shifts take only the low five bits of rs.
    assign shiftAmt = decoded.shiftByReg ? rsData[4:0] : decoded.shamt;

    always_comb begin
        case (decoded.aluOp)
            mipsPkg::aluAdd:  result = rsData + opB;
            mipsPkg::aluSub:  result = rsData - opB;
            mipsPkg::aluAnd:  result = rsData & opB;
            mipsPkg::aluOr:   result = rsData | opB;
            mipsPkg::aluXor:  result = rsData ^ opB;
            mipsPkg::aluNor:  result = ~(rsData | opB);
            mipsPkg::aluSlt:  result = {31'd0, $signed(rsData) < $signed(opB)};
            mipsPkg::aluSltu: result = {31'd0, rsData < opB};
            mipsPkg::aluSll:  result = rtData << shiftAmt;
            mipsPkg::aluSrl:  result = rtData >> shiftAmt;
            mipsPkg::aluSra:  result = $unsigned($signed(rtData) >>> shiftAmt);
            // immediate already sits in the upper half.
            mipsPkg::aluLui:  result = opB;
            default:          result = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= issueValid;
            if (issueValid) begin
                wb.regWrite <= decoded.regWrite;
                wb.writeReg <= decoded.writeReg;
                wb.data     <= result;
                wb.illegal  <= decoded.illegal;
            end
        end
    end

endmodule

//--- result/regFileResult.sv
`timescale 1ns/10ps

module regFileResult (
    input  logic         clk,
    input  logic         rstN,
    input  logic [4:0]   rsId,
    input  logic [4:0]   rtId,
    input  mipsPkg::wbT  wb,
    input  logic         hostWrite,
    input  logic [4:0]   hostAddr,
    input  logic [31:0]  hostData,
    output logic [31:0]  rsData,
    output logic [31:0]  rtData,
    output logic [31:0]  hostRdata,
    output logic [31:0]  status
);

    logic [31:0] regs [32];
    logic        illegalFlag;
    logic [15:0] retired;

    // r0 is never written, so it keeps its reset value of zero.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
            illegalFlag <= 1'b0;
            retired     <= 16'd0;
        end else begin
            // host writes only complete when no writeback is pending.
            if (wb.valid && wb.regWrite && wb.writeReg != 5'd0) begin
                regs[wb.writeReg] <= wb.data;
            end else if (hostWrite && hostAddr != 5'd0) begin
                regs[hostAddr] <= hostData;
            end
            if (wb.valid) begin
                retired <= retired + 16'd1;
                if (wb.illegal) begin
                    illegalFlag <= 1'b1;
                end
            end
        end
    end

    assign rsData    = regs[rsId];
    assign rtData    = regs[rtId];
    assign hostRdata = regs[hostAddr];

    // retired count on top, sticky illegal flag in bit 0.
    assign status = {retired, 15'd0, illegalFlag};

endmodule

//--- rtl/apbIssue.sv
`timescale 1ns/10ps

module apbIssue (
    input  logic               clk,
    input  logic               rstN,
    input  mipsPkg::apbReqT    apbReq,
    input  logic               busy,
    input  logic [31:0]        hostRdata,
    input  logic [31:0]        status,
    output mipsPkg::apbRspT    apbRsp,
    output mipsPkg::instrWordT instrWord,
    output logic               issueValid,
    output logic               hostWrite,
    output logic [4:0]         hostAddr,
    output logic [31:0]        hostData
);

    logic instrHit;
    logic statusHit;
    logic gprHit;
    logic complete;
    logic slvErr;
    logic issueNow;

    assign instrHit  = (apbReq.paddr == mipsPkg::addrInstr);
    assign statusHit = (apbReq.paddr == mipsPkg::addrStatus);
    // word aligned, 0x080 to 0x0fc.
    assign gprHit    = (apbReq.paddr[11:7] == mipsPkg::addrGprBase[11:7]) &&
                       (apbReq.paddr[1:0] == 2'b00);

    // wait states while an instruction is still in flight.
    assign complete = apbReq.psel && apbReq.penable && !busy;
    assign slvErr   = !(instrHit || statusHit || gprHit) || (apbReq.pwrite && statusHit);
    assign issueNow = complete && apbReq.pwrite && instrHit;

    always_comb begin
        apbRsp.pready  = complete;
        apbRsp.pslverr = complete && slvErr;
        apbRsp.prdata  = 32'd0;
        if (complete && !apbReq.pwrite) begin
            if (gprHit) begin
                apbRsp.prdata = hostRdata;
            end else if (statusHit) begin
                apbRsp.prdata = status;
            end
        end
    end

    assign hostWrite = complete && apbReq.pwrite && gprHit;
    assign hostAddr  = apbReq.paddr[6:2];
    assign hostData  = apbReq.pwdata;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= issueNow;
        end
    end

    always_ff @(posedge clk) begin
        if (issueNow) begin
            instrWord <= apbReq.pwdata;
        end
    end

endmodule

//--- rtl/mipsExecTop.sv
`timescale 1ns/10ps

module mipsExecTop (
    input  logic            clk,
    input  logic            rstN,
    input  mipsPkg::apbReqT apbReq,
    output mipsPkg::apbRspT apbRsp
);

    mipsPkg::instrWordT instrWord;
    mipsPkg::decodedT   decoded;
    mipsPkg::wbT        wb;
    logic               issueValid;
    logic               busy;
    logic [4:0]         rsId;
    logic [4:0]         rtId;
    logic [31:0]        rsData;
    logic [31:0]        rtData;
    logic               hostWrite;
    logic [4:0]         hostAddr;
    logic [31:0]        hostData;
    logic [31:0]        hostRdata;
    logic [31:0]        status;

    // decode or writeback still busy.
    assign busy = issueValid || wb.valid;

    apbIssue i_apbIssue (
        .clk        (clk),
        .rstN       (rstN),
        .apbReq     (apbReq),
        .busy       (busy),
        .hostRdata  (hostRdata),
        .status     (status),
        .apbRsp     (apbRsp),
        .instrWord  (instrWord),
        .issueValid (issueValid),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostData   (hostData)
    );

    instrDecoder i_instrDecoder (
        .instrWord (instrWord),
        .rsId      (rsId),
        .rtId      (rtId),
        .decoded   (decoded)
    );

    aluExecute i_aluExecute (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .decoded    (decoded),
        .rsData     (rsData),
        .rtData     (rtData),
        .wb         (wb)
    );

    regFileResult i_regFileResult (
        .clk       (clk),
        .rstN      (rstN),
        .rsId      (rsId),
        .rtId      (rtId),
        .wb        (wb),
        .hostWrite (hostWrite),
        .hostAddr  (hostAddr),
        .hostData  (hostData),
        .rsData    (rsData),
        .rtData    (rtData),
        .hostRdata (hostRdata),
        .status    (status)
    );

endmodule

//--- bench/mipsExec_properties.sv
`timescale 1ns/10ps

module mipsExecProperties (
    input logic            clk,
    input logic            rstN,
    input mipsPkg::apbReqT apbReq,
    input mipsPkg::apbRspT apbRsp,
    input logic            busy,
    input logic            issueValid,
    input mipsPkg::wbT     wb
);

    // a waiting access holds address and data.
    assert property (@(posedge clk) disable iff (!rstN)
        apbReq.psel && apbReq.penable && !apbRsp.pready |=>
        $stable(apbReq.paddr) && $stable(apbReq.pwdata))
        else $error("apb address or data changed during a wait state");

    assert property (@(posedge clk) disable iff (!rstN) issueValid |=> !issueValid)
        else $error("issueValid held for more than one cycle");

    assert property (@(posedge clk) disable iff (!rstN) wb.valid == $past(issueValid))
        else $error("wb.valid does not follow issueValid by one cycle");

    assert property (@(posedge clk) disable iff (!rstN) busy |-> !apbRsp.pready)
        else $error("pready high while an instruction is in flight");

endmodule

bind mipsExecTop mipsExecProperties i_mipsExecProperties (
    .clk        (clk),
    .rstN       (rstN),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .busy       (busy),
    .issueValid (issueValid),
    .wb         (wb)
);

//--- bench/mipsExecTb.sv
`timescale 1ns/10ps

module mipsExecTb;

    localparam int randomCount    = 300;
    localparam int directedCount  = 60;
    localparam int cyclesPerInstr = 12;
    localparam int resetCycles    = 10;
    localparam int timeoutCycles  = (randomCount + directedCount) * cyclesPerInstr + resetCycles;

    logic            clk = 1'b0;
    logic            rstN;
    mipsPkg::apbReqT apbReq;
    mipsPkg::apbRspT apbRsp;

    logic [31:0] shadow [32];
    logic [31:0] gotQ [$];
    logic [31:0] expQ [$];
    string       tagQ [$];
    int          errors = 0;
    int          cycles = 0;
    int          issued = 0;
    logic        illegalSeen = 1'b0;

    logic [5:0] rFns [16] = '{
        mipsPkg::fnAdd, mipsPkg::fnAddu, mipsPkg::fnSub, mipsPkg::fnSubu,
        mipsPkg::fnAnd, mipsPkg::fnOr, mipsPkg::fnXor, mipsPkg::fnNor,
        mipsPkg::fnSlt, mipsPkg::fnSltu, mipsPkg::fnSll, mipsPkg::fnSrl,
        mipsPkg::fnSra, mipsPkg::fnSllv, mipsPkg::fnSrlv, mipsPkg::fnSrav
    };
    logic [5:0] iOps [8] = '{
        mipsPkg::opAddi, mipsPkg::opAddiu, mipsPkg::opSlti, mipsPkg::opSltiu,
        mipsPkg::opAndi, mipsPkg::opOri, mipsPkg::opXori, mipsPkg::opLui
    };

    mipsExecTop i_mipsExecTop (
        .clk    (clk),
        .rstN   (rstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == timeoutCycles) begin
            $display("timeout: test did not finish after %0d cycles", cycles);
            errors++;
            $display("errors: %0d", errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // expected value from the instruction rules with a from rs and b from rt.
    function automatic logic [31:0] expectedResult(input logic [31:0] instr,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
        logic [31:0] se;
        logic [31:0] ze;
        logic [4:0]  sh;
        se = {{16{instr[15]}}, instr[15:0]};
        ze = {16'h0000, instr[15:0]};
        sh = instr[10:6];
        case (instr[31:26])
            6'h00: begin
                case (instr[5:0])
                    6'h20, 6'h21: return a + b;
                    6'h22, 6'h23: return a - b;
                    6'h24: return a & b;
                    6'h25: return a | b;
                    6'h26: return a ^ b;
                    6'h27: return ~(a | b);
                    6'h2a: return {31'd0, $signed(a) < $signed(b)};
                    6'h2b: return {31'd0, a < b};
                    6'h00: return b << sh;
                    6'h02: return b >> sh;
                    6'h03: return $signed(b) >>> sh;
                    6'h04: return b << a[4:0];
                    6'h06: return b >> a[4:0];
                    6'h07: return $signed(b) >>> a[4:0];
                    default: return 32'd0;
                endcase
            end
            6'h08, 6'h09: return a + se;
            6'h0a: return {31'd0, $signed(a) < $signed(se)};
            6'h0b: return {31'd0, a < se};
            6'h0c: return a & ze;
            6'h0d: return a | ze;
            6'h0e: return a ^ ze;
            6'h0f: return {instr[15:0], 16'h0000};
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic isSupported(input logic [31:0] instr);
        return (instr[31:26] == 6'h00) ?
            (instr[5:0] inside {6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
                                [6'h20:6'h27], 6'h2a, 6'h2b}) :
            (instr[31:26] inside {[6'h08:6'h0f]});
    endfunction

    function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {mipsPkg::opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [11:0] gprAddr(input logic [4:0] n);
        return mipsPkg::addrGprBase + {5'd0, n, 2'b00};
    endfunction

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string tag);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, tag, got, exp);
        end
    endtask

    task automatic compareLater(input logic [31:0] got, input logic [31:0] exp, input string tag);
        gotQ.push_back(got);
        expQ.push_back(exp);
        tagQ.push_back(tag);
    endtask

    always @(posedge clk) begin
        while (gotQ.size() > 0) begin
            checkValue(gotQ.pop_front(), expQ.pop_front(), tagQ.pop_front());
        end
    end

    // called at a falling edge and returns at the falling edge after completion.
    task automatic apbTransfer(input logic write, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slvErr);
        logic done;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(negedge clk);
        apbReq.penable = 1'b1;
        done = 1'b0;
        while (!done) begin
            #1;
            done   = apbRsp.pready;
            rdata  = apbRsp.prdata;
            slvErr = apbRsp.pslverr;
            if (!done) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        apbReq.psel    = 1'b0;
        apbReq.penable = 1'b0;
    endtask

    task automatic writeGpr(input logic [4:0] n, input logic [31:0] value);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b1, gprAddr(n), value, rdata, err);
        compareLater({31'd0, err}, 32'd0, $sformatf("pslverr on write r%0d", n));
        if (n != 5'd0) begin
            shadow[n] = value;
        end
    endtask

    task automatic readGpr(input logic [4:0] n, output logic [31:0] value);
        logic err;
        apbTransfer(1'b0, gprAddr(n), 32'd0, value, err);
        compareLater({31'd0, err}, 32'd0, $sformatf("pslverr on read r%0d", n));
    endtask

    // the read follows the issue at once and lands in the wait states.
    task automatic runInstr(input logic [31:0] instr);
        logic [31:0] rdata;
        logic [31:0] expVal;
        logic [4:0]  dest;
        logic        err;
        dest   = (instr[31:26] == 6'h00) ? instr[15:11] : instr[20:16];
        expVal = expectedResult(instr, shadow[instr[25:21]], shadow[instr[20:16]]);
        apbTransfer(1'b1, mipsPkg::addrInstr, instr, rdata, err);
        compareLater({31'd0, err}, 32'd0, $sformatf("pslverr on instr %h", instr));
        readGpr(dest, rdata);
        if (isSupported(instr) && dest != 5'd0) begin
            shadow[dest] = expVal;
        end
        illegalSeen = illegalSeen || !isSupported(instr);
        issued++;
        compareLater(rdata, shadow[dest], $sformatf("instr %h r%0d", instr, dest));
    endtask

    task automatic checkStatus(input string tag);
        logic [31:0] rdata;
        logic        err;
        apbTransfer(1'b0, mipsPkg::addrStatus, 32'd0, rdata, err);
        compareLater({31'd0, err}, 32'd0, {"pslverr on ", tag});
        compareLater(rdata, {issued[15:0], 15'd0, illegalSeen}, tag);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] instr;
        logic        err;
        int          kind;
        void'($urandom(32'hc159_e861));
        rstN   = 1'b0;
        apbReq = '0;
        for (int n = 0; n < 32; n++) begin
            shadow[n] = 32'd0;
        end
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int k = 0; k < 10; k++) begin
            writeGpr(5'd1, $urandom);
            writeGpr(5'd2, $urandom);
            runInstr(rInstr(rFns[k], 5'd1, 5'd2, 5'd3, 5'd0));
        end
        // both signs of the immediate.
        for (int k = 0; k < 8; k++) begin
            writeGpr(5'd4, $urandom);
            runInstr(iInstr(iOps[k], 5'd4, 5'd5, 16'h8001));
            runInstr(iInstr(iOps[k], 5'd4, 5'd5, 16'h7ffe));
        end
        // negative rt for sra and a shift of 3 from the low bits of rs.
        writeGpr(5'd6, 32'h8000_00f0);
        writeGpr(5'd7, 32'hffff_ffe3);
        for (int k = 10; k < 16; k++) begin
            runInstr(rInstr(rFns[k], 5'd7, 5'd6, 5'd8, 5'd4));
        end

        writeGpr(5'd0, 32'hdead_beef);
        readGpr(5'd0, rdata);
        compareLater(rdata, 32'd0, "host write to r0");
        runInstr(iInstr(mipsPkg::opAddiu, 5'd1, 5'd0, 16'h1234));
        checkStatus("status before illegal");
        // lw is not supported.
        runInstr(32'h8c22_0010);
        checkStatus("status after illegal");

        apbTransfer(1'b0, 12'h100, 32'd0, rdata, err);
        compareLater({31'd0, err}, 32'd1, "pslverr on unmapped read");
        compareLater(rdata, 32'd0, "prdata on unmapped read");
        apbTransfer(1'b1, mipsPkg::addrStatus, 32'hffff_ffff, rdata, err);
        compareLater({31'd0, err}, 32'd1, "pslverr on status write");

        for (int n = 1; n < 32; n++) begin
            writeGpr(5'(n), $urandom);
        end
        repeat (randomCount) begin
            kind = $urandom_range(0, 7);
            if (kind == 0) begin
                instr = {6'($urandom_range(16, 63)), 26'($urandom)};
            end else if (kind < 4) begin
                instr = rInstr(rFns[$urandom_range(0, 15)], 5'($urandom), 5'($urandom),
                               5'($urandom), 5'($urandom));
            end else begin
                instr = iInstr(iOps[$urandom_range(0, 7)], 5'($urandom), 5'($urandom),
                               16'($urandom));
            end
            runInstr(instr);
        end
        for (int n = 0; n < 32; n++) begin
            readGpr(5'(n), rdata);
            compareLater(rdata, shadow[n], $sformatf("final r%0d", n));
        end
        checkStatus("final status");

        repeat (2) @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
common/mipsPkg.sv
decode/instrDecoder.sv
execute/aluExecute.sv
result/regFileResult.sv
rtl/apbIssue.sv
rtl/mipsExecTop.sv
bench/mipsExec_properties.sv
bench/mipsExecTb.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, then search the log for the fail message.
rm -rf obj_dir sim.log
{ verilator --binary --assert --top-module mipsExecTb -f build.f -o simv \
    && ./obj_dir/simv; } > sim.log 2>&1 || echo "Some tests failed" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
